//--- bench/eth_rx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_asserts import eth_pkg::*; (
	input wire         gmii_rx_clk,
	input wire         reset,
	input wire         rx_start,
	input wire         rx_data_valid,
	input byte_count_t rx_bytes_valid,
	input wire         rx_commit,
	input wire         rx_drop
);

	// Open from rx_start until the verdict strobe
	logic in_frame;

	always_ff @(posedge gmii_rx_clk) begin
		if (reset)
			in_frame <= 1'b0;
		else if (rx_start)
			in_frame <= 1'b1;
		else if (rx_commit || rx_drop)
			in_frame <= 1'b0;
	end

	// One verdict for each started frame
	assert property (@(posedge gmii_rx_clk) disable iff (reset)
		(rx_commit || rx_drop) |-> (in_frame && !(rx_commit && rx_drop)))
		else $error("rx_commit and rx_drop together or without a started frame");

	// Words only leave the MAC between rx_start and the verdict
	assert property (@(posedge gmii_rx_clk) disable iff (reset)
		rx_data_valid |-> in_frame)
		else $error("rx_data_valid outside a frame");

	assert property (@(posedge gmii_rx_clk) disable iff (reset)
		rx_data_valid |-> (rx_bytes_valid >= 3'd1 && rx_bytes_valid <= 3'd4))
		else $error("rx_bytes_valid out of range");

endmodule

bind eth_rx_mac eth_rx_asserts asserts_i (
	.gmii_rx_clk    (gmii_rx_clk),
	.reset          (reset),
	.rx_start       (rx_start),
	.rx_data_valid  (rx_data_valid),
	.rx_bytes_valid (rx_bytes_valid),
	.rx_commit      (rx_commit),
	.rx_drop        (rx_drop)
);

`default_nettype wire

//--- bench/eth_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_checker import eth_pkg::*; #(
	parameter int BUF_ADDR_BITS = 8
) (
	input wire                      gmii_rx_clk,
	input wire                      reset,
	input wire  [BUF_ADDR_BITS-1:0] host_rd_addr,
	input wire                      host_rd_valid,
	input wire  [WORD_BITS-1:0]     host_rd_data,
	input wire                      frame_ready,
	input wire  [BUF_ADDR_BITS-1:0] frame_base,
	input wire  [BUF_ADDR_BITS:0]   frame_words,
	input byte_count_t              frame_last_bytes,
	input wire  [31:0]              rx_frames,
	input wire  [31:0]              rx_crc_errors
);

	localparam int DEPTH = 2 ** BUF_ADDR_BITS;

	// Expected buffer contents, filled as good frames are published
	logic [WORD_BITS-1:0] model [0:DEPTH-1];
	logic [7:0]           exp_bytes [$];
	string                test_name;
	string                test_kind;
	int                   test_errors;
	int                   total_errors;
	int                   ready_seen;
	int                   next_base;
	int                   tests_passed;
	int                   tests_failed;
	logic [31:0]          frames_at_start;
	logic [31:0]          crc_at_start;

	initial begin
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		next_base    = 0;
		test_name    = "none";
	end

	task check_value(input string what, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: test %s, %s expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task note_failure(input string what);
		$display("Test %s: %s", test_name, what);
		test_errors++;
		total_errors++;
	endtask

	task begin_test(input string name, input string kind);
		test_name       = name;
		test_kind       = kind;
		test_errors     = 0;
		ready_seen      = 0;
		frames_at_start = rx_frames;
		crc_at_start    = rx_crc_errors;
		exp_bytes.delete();
	endtask

	task push_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endtask

	// Only good frames publish and count, only bad CRC counts an error
	task end_test();
		int good;
		int bad;
		good = (test_kind == "good") ? 1 : 0;
		bad  = (test_kind == "bad") ? 1 : 0;
		check_value("frame_ready pulses", good, ready_seen);
		check_value("rx_frames increase", good, rx_frames - frames_at_start);
		check_value("rx_crc_errors increase", bad, rx_crc_errors - crc_at_start);
		if (test_errors == 0) begin
			$display("PASS %s", test_name);
			tests_passed++;
		end else begin
			$display("FAIL %s with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	task print_summary();
		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
	endtask

	function int failures();
		return total_errors;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port watch

	always @(posedge gmii_rx_clk) begin : watch
		int                   n;
		int                   words;
		int                   last;
		int                   idx;
		logic [WORD_BITS-1:0] word;
		if (!reset) begin
			if (frame_ready) begin
				ready_seen++;
				n     = exp_bytes.size();
				words = (n + 3) / 4;
				last  = (n % 4 == 0) ? 4 : n % 4;
				check_value("frame_base", next_base, frame_base);
				check_value("frame_words", words, frame_words);
				check_value("frame_last_bytes", last, frame_last_bytes);

				// Big-end first packing, zero fill after the last byte
				for (int w = 0; w < words; w++) begin
					word = '0;
					for (int b = 0; b < 4; b++) begin
						idx  = 4 * w + b;
						word = {word[23:0], (idx < n) ? exp_bytes[idx] : 8'h00};
					end
					model[(next_base + w) % DEPTH] = word;
				end
				next_base = (next_base + words) % DEPTH;
			end

			// Address is held by the host until valid
			if (host_rd_valid)
				check_value($sformatf("read word at %0d", host_rd_addr),
					model[host_rd_addr], host_rd_data);
		end
	end

endmodule

`default_nettype wire

//--- bench/eth_rx_input.txt
# name outcome data_length first_byte(hex); byte i is first_byte + 13*i, FCS added by the testbench
# outcome: good, bad (corrupt FCS), runt (ends in preamble), badpre, rxer (error on first byte)
good_len60 good 60 10
good_len61 good 61 20
bad_crc bad 48 30
good_after_bad good 62 40
runt_preamble runt 20 50
bad_preamble badpre 40 60
rx_er_first rxer 40 70
good_len63 good 63 80
good_len64 good 64 90
bad_crc_short bad 33 a0
good_wrap good 45 b0
good_len46 good 46 c0
good_len47 good 47 d0
good_len8 good 8 e0

//--- bench/eth_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_tb import eth_pkg::*; ();

	// Small ring so that wrap-around comes quickly
	localparam int BUF_BITS = 5;
	localparam int DEPTH    = 2 ** BUF_BITS;

	logic                 gmii_rx_clk;
	logic                 reset;
	logic                 gmii_rx_en;
	logic                 gmii_rx_er;
	logic [7:0]           gmii_rx_data;
	logic                 host_rd_req;
	logic [BUF_BITS-1:0]  host_rd_addr;
	logic                 host_rd_valid;
	logic [WORD_BITS-1:0] host_rd_data;
	logic                 frame_ready;
	logic [BUF_BITS-1:0]  frame_base;
	logic [BUF_BITS:0]    frame_words;
	byte_count_t          frame_last_bytes;
	logic [31:0]          rx_frames;
	logic [31:0]          rx_crc_errors;

	logic [7:0] frame_bytes [$];
	int         exp_frames;
	int         exp_crc;
	int         prev_base;
	int         prev_words;
	bit         have_prev;

	eth_rx_subsystem #(.BUF_ADDR_BITS(BUF_BITS)) dut_i (.*);

	eth_rx_checker #(.BUF_ADDR_BITS(BUF_BITS)) checker_i (
		.gmii_rx_clk      (gmii_rx_clk),
		.reset            (reset),
		.host_rd_addr     (host_rd_addr),
		.host_rd_valid    (host_rd_valid),
		.host_rd_data     (host_rd_data),
		.frame_ready      (frame_ready),
		.frame_base       (frame_base),
		.frame_words      (frame_words),
		.frame_last_bytes (frame_last_bytes),
		.rx_frames        (rx_frames),
		.rx_crc_errors    (rx_crc_errors)
	);

	initial begin
		gmii_rx_clk = 1'b0;
		forever #2 gmii_rx_clk = ~gmii_rx_clk;
	end

	// Inputs change 1 ns after the rising edge
	task next_cycle();
		@(posedge gmii_rx_clk);
		#1;
	endtask

	task drive_byte(input logic [7:0] d, input logic er);
		gmii_rx_en   = 1'b1;
		gmii_rx_er   = er;
		gmii_rx_data = d;
		next_cycle();
	endtask

	// Reflected CRC-32 that goes out LSB first
	function automatic logic [31:0] fcs_of_frame();
		logic [31:0] c;
		c = 32'hFFFF_FFFF;
		foreach (frame_bytes[i]) begin
			c = c ^ {24'h0, frame_bytes[i]};
			for (int k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		return ~c;
	endfunction

	task send_frame(input string kind);
		logic [31:0] fcs;
		int          pre_len;
		logic [7:0]  pre;
		pre_len = (kind == "runt") ? 4 : 7;
		for (int i = 0; i < pre_len; i++) begin
			pre = (kind == "badpre" && i == 3) ? 8'h5C : GMII_PREAMBLE;
			drive_byte(pre, kind == "rxer" && i == 0);
		end
		if (kind != "runt") begin
			drive_byte(GMII_SFD, 1'b0);
			foreach (frame_bytes[i])
				drive_byte(frame_bytes[i], 1'b0);
			fcs = fcs_of_frame();
			if (kind == "bad")
				fcs = fcs ^ 32'h0000_0001;
			for (int i = 0; i < 4; i++)
				drive_byte(fcs[8*i +: 8], 1'b0);
		end
		gmii_rx_en   = 1'b0;
		gmii_rx_er   = 1'b0;
		gmii_rx_data = 8'h00;
	endtask

	// Request held until valid and then dropped for one cycle
	task read_word(input int addr);
		int waited;
		bit got;
		host_rd_addr = addr[BUF_BITS-1:0];
		host_rd_req  = 1'b1;
		waited       = 0;
		got          = 1'b0;
		while (!got && waited < 2) begin
			next_cycle();
			waited++;
			got = host_rd_valid;
		end
		if (!got)
			checker_i.note_failure($sformatf("no host_rd_valid within two cycles at %0d", addr));
		host_rd_req = 1'b0;
		next_cycle();
	endtask

	task read_frame(input int base, input int words);
		for (int w = 0; w < words; w++)
			read_word((base + w) % DEPTH);
	endtask

	task wait_counters();
		int waited;
		waited = 0;
		while ((rx_frames != exp_frames || rx_crc_errors != exp_crc) && waited < 16) begin
			next_cycle();
			waited++;
		end
		if (rx_frames != exp_frames || rx_crc_errors != exp_crc)
			checker_i.note_failure("frame counters did not settle in time");
	endtask

	task run_test(input string name, input string kind, input int len, input int first);
		frame_bytes.delete();
		checker_i.begin_test(name, kind);
		for (int i = 0; i < len; i++) begin
			frame_bytes.push_back(8'(first + 13 * i));
			checker_i.push_byte(8'(first + 13 * i));
		end
		if (kind == "good")
			exp_frames++;
		if (kind == "bad")
			exp_crc++;

		// Previous frame is read again while this one arrives
		fork
			send_frame(kind);
			if (have_prev)
				read_frame(prev_base, prev_words);
		join
		wait_counters();
		if (kind == "good") begin
			prev_base  = frame_base;
			prev_words = frame_words;
			have_prev  = 1'b1;
			read_frame(prev_base, prev_words);
		end
		repeat ($urandom_range(20, 12))
			next_cycle();
		checker_i.end_test();
	endtask

	initial begin
		int    fd;
		int    fields;
		int    len;
		int    first;
		string line;
		string name;
		string kind;
		reset        = 1'b1;
		gmii_rx_en   = 1'b0;
		gmii_rx_er   = 1'b0;
		gmii_rx_data = 8'h00;
		host_rd_req  = 1'b0;
		host_rd_addr = '0;
		exp_frames   = 0;
		exp_crc      = 0;
		have_prev    = 1'b0;
		void'($urandom(41603));
		repeat (3) @(posedge gmii_rx_clk);
		#1;
		reset = 1'b0;
		next_cycle();

		fd = $fopen("bench/eth_rx_input.txt", "r");
		if (fd == 0) begin
			checker_i.note_failure("cannot open bench/eth_rx_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != 8'h23) begin
					fields = $sscanf(line, "%s %s %d %h", name, kind, len, first);
					if (fields == 4)
						run_test(name, kind, len, first);
				end
			end
			$fclose(fd);
		end

		checker_i.print_summary();
		if (checker_i.failures() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
src/eth_pkg.sv
src/crc32_ethernet.sv
src/eth_rx_mac.sv
src/rx_frame_writer.sv
src/frame_buffer_arbiter.sv
src/eth_rx_subsystem.sv
bench/eth_rx_checker.sv
bench/eth_rx_asserts.sv
bench/eth_rx_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module eth_rx_tb \
	-f compile.f -o eth_rx_sim > sim.log 2>&1 &&
	./obj_dir/eth_rx_sim >> sim.log 2>&1 ||
	echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- src/crc32_ethernet.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_ethernet (
	input wire         gmii_rx_clk,
	input wire         reset,
	input wire         crc_reset,
	input wire         update,
	input wire  [7:0]  din,
	output logic [31:0] crc
);

	// IEEE 802.3 generator polynomial, MSB-first form
	localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

	logic [31:0] crc_reg;

	// One byte through the shift register, bit 0 goes first on the wire
	function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = c;
		for (i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r  = {r[30:0], 1'b0};
			if (fb)
				r = r ^ CRC_POLY;
		end
		return r;
	endfunction

	// Preset to all ones at the start of every frame
	always_ff @(posedge gmii_rx_clk) begin
		if (reset || crc_reset)
			crc_reg <= 32'hFFFF_FFFF;
		else if (update)
			crc_reg <= crc_next(crc_reg, din);
	end

	// Reflect each byte and invert, so the result lines up with FCS bytes
	// packed first byte in the top lane
	for (genvar b = 0; b < 4; b++) begin : g_byte
		for (genvar j = 0; j < 8; j++) begin : g_bit
			assign crc[8*b + j] = ~crc_reg[8*b + 7 - j];
		end
	end

endmodule

`default_nettype wire

//--- src/eth_pkg.sv
`default_nettype none

package eth_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Receive FSM

	// Four-bit state code with IDLE at zero
	typedef enum logic [3:0] {
		IDLE       = 4'h0,
		DROP       = 4'h1,
		PREAMBLE   = 4'h2,
		FRAME_DATA = 4'h3,
		CRC        = 4'h4
	} rx_state_t;

	//////////////////////////////////////////////////////////////////////////////
	// GMII framing bytes

	localparam logic [7:0] GMII_PREAMBLE = 8'h55;
	localparam logic [7:0] GMII_SFD      = 8'hD5;

	//////////////////////////////////////////////////////////////////////////////
	// Data path widths

	// Frame data moves as 32-bit words with the first byte in the top lane
	localparam int WORD_BITS = 32;

	// Valid bytes in one word from 1 to 4
	typedef logic [2:0] byte_count_t;

	// Default buffer depth as log2 of words
	localparam int ADDR_BITS_DEFAULT = 8;

endpackage

`default_nettype wire

//--- src/eth_rx_mac.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_mac import eth_pkg::*; (
	input wire                   gmii_rx_clk,
	input wire                   reset,
	input wire                   gmii_rx_en,
	input wire                   gmii_rx_er,
	input wire  [7:0]            gmii_rx_data,
	output logic                 rx_start,
	output logic                 rx_data_valid,
	output logic [WORD_BITS-1:0] rx_data,
	output byte_count_t          rx_bytes_valid,
	output logic                 rx_commit,
	output logic                 rx_drop
);

	rx_state_t            state;
	logic [1:0]           byte_pos;
	logic [WORD_BITS-1:0] pending_word;
	logic [WORD_BITS-1:0] next_word;
	logic                 held_valid;
	logic [WORD_BITS-1:0] held_word;

	//////////////////////////////////////////////////////////////////////////////
	// CRC over the frame bytes

	logic        crc_reset;
	logic        crc_update;
	logic [31:0] crc_now;
	logic [31:0] crc_dly [0:4];

	// Preset while waiting for the SFD, then one byte per cycle
	assign crc_reset  = (state == PREAMBLE);
	assign crc_update = gmii_rx_en && (state == FRAME_DATA);

	crc32_ethernet crc_i (
		.gmii_rx_clk (gmii_rx_clk),
		.reset       (reset),
		.crc_reset   (crc_reset),
		.update      (crc_update),
		.din         (gmii_rx_data),
		.crc         (crc_now)
	);

	// Five stages line up the CRC of the data bytes alone
	// with the FCS sitting in the pending word during the CRC state
	always_ff @(posedge gmii_rx_clk) begin
		crc_dly[0] <= crc_now;
		crc_dly[1] <= crc_dly[0];
		crc_dly[2] <= crc_dly[1];
		crc_dly[3] <= crc_dly[2];
		crc_dly[4] <= crc_dly[3];
	end

	//////////////////////////////////////////////////////////////////////////////
	// Word packing

	// Shift in from the bottom, first byte ends up in the top lane
	assign next_word = {pending_word[WORD_BITS-9:0], gmii_rx_data};

	always_ff @(posedge gmii_rx_clk) begin
		if (state == FRAME_DATA) begin
			if (gmii_rx_en) begin
				pending_word <= next_word;

				// Word complete, hold it and push out the one before
				if (byte_pos == 2'd3) begin
					held_word      <= next_word;
					rx_data        <= held_word;
					rx_bytes_valid <= 3'd4;
				end
			end else begin
				// Leftover bytes are data, the rest of the held word is FCS
				rx_bytes_valid <= {1'b0, byte_pos};
				case (byte_pos)
					2'd1:    rx_data <= {held_word[31:24], 24'h0};
					2'd2:    rx_data <= {held_word[31:16], 16'h0};
					2'd3:    rx_data <= {held_word[31:8], 8'h0};
					default: rx_data <= held_word;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge gmii_rx_clk) begin
		if (reset) begin
			state         <= IDLE;
			byte_pos      <= 2'd0;
			held_valid    <= 1'b0;
			rx_start      <= 1'b0;
			rx_data_valid <= 1'b0;
			rx_commit     <= 1'b0;
			rx_drop       <= 1'b0;
		end else begin
			// Strobes are single cycle
			rx_start      <= 1'b0;
			rx_data_valid <= 1'b0;
			rx_commit     <= 1'b0;
			rx_drop       <= 1'b0;

			case (state)
				// First byte must be clean preamble
				IDLE: begin
					if (gmii_rx_en) begin
						if ((gmii_rx_data == GMII_PREAMBLE) && !gmii_rx_er)
							state <= PREAMBLE;
						else
							state <= DROP;
					end
				end

				// Runts and bad preamble bytes never reach the writer
				PREAMBLE: begin
					if (!gmii_rx_en) begin
						state <= IDLE;
					end else if (gmii_rx_data == GMII_SFD) begin
						rx_start   <= 1'b1;
						byte_pos   <= 2'd0;
						held_valid <= 1'b0;
						state      <= FRAME_DATA;
					end else if (gmii_rx_data != GMII_PREAMBLE) begin
						state <= DROP;
					end
				end

				FRAME_DATA: begin
					if (!gmii_rx_en) begin
						// Flush a partial word, if any
						rx_data_valid <= (byte_pos != 2'd0) && held_valid;
						state         <= CRC;
					end else begin
						byte_pos <= byte_pos + 2'd1;
						if (byte_pos == 2'd3) begin
							held_valid    <= 1'b1;
							rx_data_valid <= held_valid;
						end
					end
				end

				// Last four bytes on the wire against the delayed CRC
				CRC: begin
					state <= IDLE;
					if (crc_dly[4] == pending_word)
						rx_commit <= 1'b1;
					else
						rx_drop <= 1'b1;
				end

				// Skip the rest of a broken frame
				DROP: begin
					if (!gmii_rx_en)
						state <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/eth_rx_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_subsystem import eth_pkg::*; #(
	parameter int BUF_ADDR_BITS = ADDR_BITS_DEFAULT
) (
	input wire                       gmii_rx_clk,
	input wire                       reset,

	// GMII receive
	input wire                       gmii_rx_en,
	input wire                       gmii_rx_er,
	input wire  [7:0]                gmii_rx_data,

	// Host read port
	input wire                       host_rd_req,
	input wire  [BUF_ADDR_BITS-1:0]  host_rd_addr,
	output logic                     host_rd_valid,
	output logic [WORD_BITS-1:0]     host_rd_data,

	// Frame notices and counters
	output logic                     frame_ready,
	output logic [BUF_ADDR_BITS-1:0] frame_base,
	output logic [BUF_ADDR_BITS:0]   frame_words,
	output byte_count_t              frame_last_bytes,
	output logic [31:0]              rx_frames,
	output logic [31:0]              rx_crc_errors
);

	// MAC to writer
	logic                     rx_start;
	logic                     rx_data_valid;
	logic [WORD_BITS-1:0]     rx_data;
	byte_count_t              rx_bytes_valid;
	logic                     rx_commit;
	logic                     rx_drop;

	// Writer to memory
	logic                     wr_en;
	logic [BUF_ADDR_BITS-1:0] wr_addr;
	logic [WORD_BITS-1:0]     wr_data;

	eth_rx_mac mac_i (
		.gmii_rx_clk    (gmii_rx_clk),
		.reset          (reset),
		.gmii_rx_en     (gmii_rx_en),
		.gmii_rx_er     (gmii_rx_er),
		.gmii_rx_data   (gmii_rx_data),
		.rx_start       (rx_start),
		.rx_data_valid  (rx_data_valid),
		.rx_data        (rx_data),
		.rx_bytes_valid (rx_bytes_valid),
		.rx_commit      (rx_commit),
		.rx_drop        (rx_drop)
	);

	rx_frame_writer #(
		.BUF_ADDR_BITS (BUF_ADDR_BITS)
	) writer_i (
		.gmii_rx_clk      (gmii_rx_clk),
		.reset            (reset),
		.rx_start         (rx_start),
		.rx_data_valid    (rx_data_valid),
		.rx_data          (rx_data),
		.rx_bytes_valid   (rx_bytes_valid),
		.rx_commit        (rx_commit),
		.rx_drop          (rx_drop),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.frame_ready      (frame_ready),
		.frame_base       (frame_base),
		.frame_words      (frame_words),
		.frame_last_bytes (frame_last_bytes),
		.rx_frames        (rx_frames),
		.rx_crc_errors    (rx_crc_errors)
	);

	frame_buffer_arbiter #(
		.BUF_ADDR_BITS (BUF_ADDR_BITS)
	) arbiter_i (
		.gmii_rx_clk   (gmii_rx_clk),
		.reset         (reset),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.host_rd_req   (host_rd_req),
		.host_rd_addr  (host_rd_addr),
		.host_rd_valid (host_rd_valid),
		.host_rd_data  (host_rd_data)
	);

endmodule

`default_nettype wire

//--- src/frame_buffer_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_arbiter import eth_pkg::*; #(
	parameter int BUF_ADDR_BITS = 8
) (
	input wire                       gmii_rx_clk,
	input wire                       reset,
	input wire                       wr_en,
	input wire  [BUF_ADDR_BITS-1:0]  wr_addr,
	input wire  [WORD_BITS-1:0]      wr_data,
	input wire                       host_rd_req,
	input wire  [BUF_ADDR_BITS-1:0]  host_rd_addr,
	output logic                     host_rd_valid,
	output logic [WORD_BITS-1:0]     host_rd_data
);

	localparam int DEPTH = 2 ** BUF_ADDR_BITS;

	logic [WORD_BITS-1:0] mem [0:DEPTH-1];
	logic                 rd_pending;
	logic                 rd_grant;

	// Writer always wins, host gets any cycle without a write
	// A request already answered waits for the host to drop it
	assign rd_grant = host_rd_req && !rd_pending && !wr_en;

	//////////////////////////////////////////////////////////////////////////////
	// Word memory

	always_ff @(posedge gmii_rx_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_grant)
			host_rd_data <= mem[host_rd_addr];
	end

	//////////////////////////////////////////////////////////////////////////////
	// Read handshake

	always_ff @(posedge gmii_rx_clk) begin
		if (reset) begin
			host_rd_valid <= 1'b0;
			rd_pending    <= 1'b0;
		end else begin
			host_rd_valid <= rd_grant;

			// Answered, hold off until the request level goes away
			if (rd_grant)
				rd_pending <= 1'b1;
			else if (!host_rd_req)
				rd_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/rx_frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer import eth_pkg::*; #(
	parameter int BUF_ADDR_BITS = 8
) (
	input wire                       gmii_rx_clk,
	input wire                       reset,
	input wire                       rx_start,
	input wire                       rx_data_valid,
	input wire  [WORD_BITS-1:0]      rx_data,
	input wire  byte_count_t         rx_bytes_valid,
	input wire                       rx_commit,
	input wire                       rx_drop,
	output logic                     wr_en,
	output logic [BUF_ADDR_BITS-1:0] wr_addr,
	output logic [WORD_BITS-1:0]     wr_data,
	output logic                     frame_ready,
	output logic [BUF_ADDR_BITS-1:0] frame_base,
	output logic [BUF_ADDR_BITS:0]   frame_words,
	output byte_count_t              frame_last_bytes,
	output logic [31:0]              rx_frames,
	output logic [31:0]              rx_crc_errors
);

	logic [BUF_ADDR_BITS-1:0] wr_ptr;
	logic [BUF_ADDR_BITS-1:0] base_ptr;
	logic [BUF_ADDR_BITS:0]   word_count;
	byte_count_t              last_bytes;

	// Pointer, strobes and counters
	always_ff @(posedge gmii_rx_clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			wr_en         <= 1'b0;
			frame_ready   <= 1'b0;
			rx_frames     <= 32'd0;
			rx_crc_errors <= 32'd0;
		end else begin
			wr_en       <= rx_data_valid;
			frame_ready <= rx_commit;

			// Ring buffer, pointer wraps on its own
			if (rx_data_valid)
				wr_ptr <= wr_ptr + 1'b1;

			if (rx_commit)
				rx_frames <= rx_frames + 32'd1;

			// Bad frame, give its space back
			if (rx_drop) begin
				wr_ptr        <= base_ptr;
				rx_crc_errors <= rx_crc_errors + 32'd1;
			end
		end
	end

	// Per-frame bookkeeping and write data
	always_ff @(posedge gmii_rx_clk) begin
		if (rx_start) begin
			base_ptr   <= wr_ptr;
			word_count <= '0;
		end
		if (rx_data_valid) begin
			wr_addr    <= wr_ptr;
			wr_data    <= rx_data;
			word_count <= word_count + 1'b1;
			last_bytes <= rx_bytes_valid;
		end
		if (rx_commit) begin
			frame_base       <= base_ptr;
			frame_words      <= word_count;
			frame_last_bytes <= last_bytes;
		end
	end

endmodule

`default_nettype wire
